// ==== hw/ex_pkg.sv ====
package ex_pkg;

  // RV32I datapath width
  localparam int data_w = 32;

  // Number of lines in the one-hot ALU operation bus
  localparam int alu_op_n = 11;

  // Bit positions in the one-hot operation bus
  localparam int alu_add  = 0;
  localparam int alu_sub  = 1;
  localparam int alu_sll  = 2;
  localparam int alu_slt  = 3;
  localparam int alu_sltu = 4;
  localparam int alu_xor  = 5;
  localparam int alu_srl  = 6;
  localparam int alu_sra  = 7;
  localparam int alu_or   = 8;
  localparam int alu_and  = 9;
  // Return address pc+4 for jumps
  localparam int alu_pc   = 10;

  // Major opcodes handled by the stage
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;

  // Same 32-bit word seen as R-type or as I-type fields
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } instr_u;

  // One instruction with its pc and register operands
  typedef struct packed {
    instr_u             instr;
    logic [data_w-1:0]  pc;
    logic [data_w-1:0]  rs1_data;
    logic [data_w-1:0]  rs2_data;
  } ex_req_t;

  // Decoded control for the datapath
  typedef struct packed {
    logic [alu_op_n-1:0] alu_opt;
    logic                sub;
    logic                a_pc;
    logic                a_zero;
    logic                b_imm;
    logic [data_w-1:0]   imm;
    logic                is_branch;
    logic                is_jal;
    logic                is_jalr;
    logic [2:0]          funct3;
  } ex_ctrl_t;

  // Registered stage response
  typedef struct packed {
    logic [data_w-1:0] result;
    logic              taken;
    logic [data_w-1:0] target;
  } ex_rsp_t;

endpackage

// ==== hw/ex_decoder.sv ====
`timescale 1ns/10ps

module ex_decoder import ex_pkg::*; (
  input  instr_u   instr,
  output ex_ctrl_t ctrl
);

  // Map funct3 to one ALU operation
  // Register form uses funct7 bit 5 for sub, both forms use it for sra
  function automatic logic [alu_op_n-1:0] alu_from_funct3(
    input logic [2:0] f3,
    input logic       alt,
    input logic       is_reg
  );
    logic [alu_op_n-1:0] onehot;
    onehot = '0;
    case (f3)
      3'b000:  onehot[(is_reg && alt) ? alu_sub : alu_add] = 1'b1;
      3'b001:  onehot[alu_sll] = 1'b1;
      3'b010:  onehot[alu_slt] = 1'b1;
      3'b011:  onehot[alu_sltu] = 1'b1;
      3'b100:  onehot[alu_xor] = 1'b1;
      3'b101:  onehot[alt ? alu_sra : alu_srl] = 1'b1;
      3'b110:  onehot[alu_or] = 1'b1;
      default: onehot[alu_and] = 1'b1;
    endcase
    return onehot;
  endfunction

  logic [data_w-1:0] imm_i;
  logic [data_w-1:0] imm_u;
  logic [data_w-1:0] imm_b;
  logic [data_w-1:0] imm_j;

  // I-type immediate straight from the I view
  assign imm_i = {{(data_w-12){instr.i.imm12[11]}}, instr.i.imm12};

  // U, B and J immediates are scattered over the R view fields
  assign imm_u = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3, 12'b0};
  assign imm_b = {{(data_w-12){instr.r.funct7[6]}}, instr.r.rd[0],
                  instr.r.funct7[5:0], instr.r.rd[4:1], 1'b0};
  assign imm_j = {{(data_w-20){instr.r.funct7[6]}}, instr.r.rs1, instr.r.funct3,
                  instr.r.rs2[0], instr.r.funct7[5:0], instr.r.rs2[4:1], 1'b0};

  always_comb begin
    ctrl        = '0;
    ctrl.funct3 = instr.r.funct3;
    case (instr.r.opcode)
      op_op: begin
        ctrl.alu_opt = alu_from_funct3(instr.r.funct3, instr.r.funct7[5], 1'b1);
      end
      op_imm: begin
        // Shift amount is the low immediate bits
        ctrl.alu_opt = alu_from_funct3(instr.i.funct3, instr.r.funct7[5], 1'b0);
        ctrl.b_imm   = 1'b1;
        ctrl.imm     = imm_i;
      end
      op_lui: begin
        // 0 + imm
        ctrl.alu_opt[alu_add] = 1'b1;
        ctrl.a_zero           = 1'b1;
        ctrl.b_imm            = 1'b1;
        ctrl.imm              = imm_u;
      end
      op_auipc: begin
        ctrl.alu_opt[alu_add] = 1'b1;
        ctrl.a_pc             = 1'b1;
        ctrl.b_imm            = 1'b1;
        ctrl.imm              = imm_u;
      end
      op_jal: begin
        ctrl.alu_opt[alu_pc] = 1'b1;
        ctrl.a_pc            = 1'b1;
        ctrl.b_imm           = 1'b1;
        ctrl.imm             = imm_j;
        ctrl.is_jal          = 1'b1;
      end
      op_jalr: begin
        ctrl.alu_opt[alu_pc] = 1'b1;
        ctrl.b_imm           = 1'b1;
        ctrl.imm             = imm_i;
        ctrl.is_jalr         = 1'b1;
      end
      op_branch: begin
        // rs1 - rs2 drives the compare flags
        ctrl.alu_opt[alu_sub] = 1'b1;
        ctrl.imm              = imm_b;
        ctrl.is_branch        = 1'b1;
      end
      default: begin
        ctrl.funct3 = '0;
      end
    endcase
    // Compares need the adder in subtract mode
    ctrl.sub = ctrl.alu_opt[alu_sub] | ctrl.alu_opt[alu_slt] | ctrl.alu_opt[alu_sltu];
  end

endmodule

// ==== hw/ex_adder.sv ====
`timescale 1ns/10ps

module ex_adder import ex_pkg::*; (
  input  logic [data_w-1:0] a,
  input  logic [data_w-1:0] b,
  input  logic [data_w-1:0] pc,
  input  logic              sub,
  output logic [data_w-1:0] adder_sum,
  output logic [data_w-1:0] adder_pc,
  output logic              signed_flag,
  output logic              unsigned_flag
);

  logic [data_w-1:0] b_op;
  logic              carry;
  logic              overflow;

  // Two's complement subtract is a + ~b + 1
  assign b_op = b ^ {data_w{sub}};

  // Single carry chain, carry in is the subtract bit
  assign {carry, adder_sum} = {1'b0, a} + {1'b0, b_op} + {{data_w{1'b0}}, sub};

  // Operands of equal sign giving a result of other sign
  assign overflow = (a[data_w-1] == b_op[data_w-1]) &&
                    (adder_sum[data_w-1] != a[data_w-1]);

  // Borrow out of a - b means a < b unsigned
  assign unsigned_flag = ~carry;

  // Sign of the difference, flipped when it overflowed
  assign signed_flag = adder_sum[data_w-1] ^ overflow;

  // Link address for jal and jalr
  assign adder_pc = pc + data_w'(4);

endmodule

// ==== hw/ex_alu.sv ====
`timescale 1ns/10ps

module ex_alu import ex_pkg::*; (
  input  logic [alu_op_n-1:0] alu_opt_bus,
  input  logic [data_w-1:0]   alu_a_data,
  input  logic [data_w-1:0]   alu_b_data,
  input  logic [data_w-1:0]   adder_sum,
  input  logic [data_w-1:0]   adder_pc,
  input  logic                signed_flag,
  input  logic                unsigned_flag,
  output logic [data_w-1:0]   alu_result
);

  // Mirror bit order so one right shifter also does left shifts
  function automatic logic [data_w-1:0] reverse_bits(input logic [data_w-1:0] in);
    logic [data_w-1:0] out;
    for (int k = 0; k < data_w; k++) begin
      out[data_w-1-k] = in[k];
    end
    return out;
  endfunction

  logic [data_w-1:0] and_result;
  logic [data_w-1:0] or_result;
  logic [data_w-1:0] xor_result;
  logic [data_w-1:0] slt_result;
  logic [data_w-1:0] sltu_result;
  logic [4:0]        shamt;
  logic [data_w-1:0] shift_in;
  logic [data_w-1:0] shift_out;
  logic [data_w-1:0] sra_mask;
  logic [data_w-1:0] sll_result;
  logic [data_w-1:0] srl_result;
  logic [data_w-1:0] sra_result;

  // Bitwise ops
  assign and_result = alu_a_data & alu_b_data;
  assign or_result  = alu_a_data | alu_b_data;
  assign xor_result = alu_a_data ^ alu_b_data;

  // Set-less-than comes from the adder flags
  assign slt_result  = {{(data_w-1){1'b0}}, signed_flag};
  assign sltu_result = {{(data_w-1){1'b0}}, unsigned_flag};

  // Only the low five bits of b count as shift amount
  assign shamt = alu_b_data[4:0];

  assign shift_in  = alu_opt_bus[alu_sll] ? reverse_bits(alu_a_data) : alu_a_data;
  assign shift_out = shift_in >> shamt;

  assign srl_result = shift_out;
  assign sll_result = reverse_bits(shift_out);

  // Mask marks the bits that survived, the rest take the sign
  assign sra_mask   = {data_w{1'b1}} >> shamt;
  assign sra_result = (shift_out & sra_mask) |
                      ({data_w{alu_a_data[data_w-1]}} & ~sra_mask);

  // AND-OR select, an empty bus gives zero
  assign alu_result =
    ({data_w{alu_opt_bus[alu_add]}}  & adder_sum)   |
    ({data_w{alu_opt_bus[alu_sub]}}  & adder_sum)   |
    ({data_w{alu_opt_bus[alu_sll]}}  & sll_result)  |
    ({data_w{alu_opt_bus[alu_slt]}}  & slt_result)  |
    ({data_w{alu_opt_bus[alu_sltu]}} & sltu_result) |
    ({data_w{alu_opt_bus[alu_xor]}}  & xor_result)  |
    ({data_w{alu_opt_bus[alu_srl]}}  & srl_result)  |
    ({data_w{alu_opt_bus[alu_sra]}}  & sra_result)  |
    ({data_w{alu_opt_bus[alu_or]}}   & or_result)   |
    ({data_w{alu_opt_bus[alu_and]}}  & and_result)  |
    ({data_w{alu_opt_bus[alu_pc]}}   & adder_pc);

endmodule

// ==== hw/ex_branch.sv ====
`timescale 1ns/10ps

module ex_branch import ex_pkg::*; (
  input  ex_ctrl_t          ctrl,
  input  logic [data_w-1:0] pc,
  input  logic [data_w-1:0] rs1_data,
  input  logic [data_w-1:0] adder_sum,
  input  logic              signed_flag,
  input  logic              unsigned_flag,
  output logic              taken,
  output logic [data_w-1:0] target
);

  logic              equal;
  logic              cond;
  logic [data_w-1:0] pc_target;
  logic [data_w-1:0] reg_target;

  // rs1 - rs2 is zero only for equal operands
  assign equal = (adder_sum == '0);

  // Condition by funct3, 010 and 011 are not branches
  always_comb begin
    case (ctrl.funct3)
      3'b000:  cond = equal;
      3'b001:  cond = ~equal;
      3'b100:  cond = signed_flag;
      3'b101:  cond = ~signed_flag;
      3'b110:  cond = unsigned_flag;
      3'b111:  cond = ~unsigned_flag;
      default: cond = 1'b0;
    endcase
  end

  // Jumps always go
  assign taken = (ctrl.is_branch & cond) | ctrl.is_jal | ctrl.is_jalr;

  // pc relative for branches and jal
  assign pc_target = pc + ctrl.imm;

  // jalr drops bit 0 of rs1 + imm
  assign reg_target = (rs1_data + ctrl.imm) & ~data_w'(1);

  always_comb begin
    if (ctrl.is_jalr) begin
      target = reg_target;
    end else if (ctrl.is_branch || ctrl.is_jal) begin
      target = pc_target;
    end else begin
      target = '0;
    end
  end

endmodule

// ==== hw/ex_stage.sv ====
`timescale 1ns/10ps

module ex_stage import ex_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  input  ex_req_t in_req,
  output logic    out_valid,
  output ex_rsp_t out_rsp
);

  ex_ctrl_t          ctrl;
  logic [data_w-1:0] op_a;
  logic [data_w-1:0] op_b;
  logic [data_w-1:0] adder_sum;
  logic [data_w-1:0] adder_pc;
  logic              signed_flag;
  logic              unsigned_flag;
  logic [data_w-1:0] alu_result;
  logic              taken;
  logic [data_w-1:0] target;
  ex_rsp_t           rsp_next;

  ex_decoder decoder_i (
    .instr (in_req.instr),
    .ctrl  (ctrl)
  );

  // Operand a: zero for lui, pc for auipc/jal, else rs1
  always_comb begin
    if (ctrl.a_zero) begin
      op_a = '0;
    end else if (ctrl.a_pc) begin
      op_a = in_req.pc;
    end else begin
      op_a = in_req.rs1_data;
    end
  end

  // Operand b: immediate or rs2
  assign op_b = ctrl.b_imm ? ctrl.imm : in_req.rs2_data;

  ex_adder adder_i (
    .a             (op_a),
    .b             (op_b),
    .pc            (in_req.pc),
    .sub           (ctrl.sub),
    .adder_sum     (adder_sum),
    .adder_pc      (adder_pc),
    .signed_flag   (signed_flag),
    .unsigned_flag (unsigned_flag)
  );

  ex_alu alu_i (
    .alu_opt_bus   (ctrl.alu_opt),
    .alu_a_data    (op_a),
    .alu_b_data    (op_b),
    .adder_sum     (adder_sum),
    .adder_pc      (adder_pc),
    .signed_flag   (signed_flag),
    .unsigned_flag (unsigned_flag),
    .alu_result    (alu_result)
  );

  ex_branch branch_i (
    .ctrl          (ctrl),
    .pc            (in_req.pc),
    .rs1_data      (in_req.rs1_data),
    .adder_sum     (adder_sum),
    .signed_flag   (signed_flag),
    .unsigned_flag (unsigned_flag),
    .taken         (taken),
    .target        (target)
  );

  assign rsp_next = '{result: alu_result, taken: taken, target: target};

  // One cycle latency, response held between strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_rsp   <= '0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        out_rsp <= rsp_next;
      end
    end
  end

endmodule

// ==== tests/ex_stage_tb.sv ====
`timescale 1ns/10ps

module ex_stage_tb import ex_pkg::*; ();

  // Cycles to wait for out_valid before giving up
  localparam int resp_timeout = 8;

  logic    clk = 1'b0;
  logic    rst;
  logic    in_valid;
  ex_req_t in_req;
  logic    out_valid;
  ex_rsp_t out_rsp;

  integer seed = 32'hb18e_6bf0;
  int     check_count = 0;
  int     error_count = 0;

  ex_stage dut_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_rsp   (out_rsp)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // Reference model straight from the RV32I rules
  function automatic ex_rsp_t model_rsp(input ex_req_t req);
    ex_rsp_t     rsp;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sra;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [2:0]  f3;
    logic        lt;
    logic        ltu;
    w     = req.instr;
    f3    = w[14:12];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    a     = req.rs1_data;
    // OP-IMM compares and shifts against the immediate
    b     = (w[6:0] == op_imm) ? imm_i : req.rs2_data;
    sra   = $signed(a) >>> b[4:0];
    lt    = $signed(a) < $signed(b);
    ltu   = a < b;
    rsp   = '0;
    case (w[6:0])
      op_op, op_imm: begin
        case (f3)
          3'b000:  rsp.result = (w[30] && w[6:0] == op_op) ? a - b : a + b;
          3'b001:  rsp.result = a << b[4:0];
          3'b010:  rsp.result = {31'b0, lt};
          3'b011:  rsp.result = {31'b0, ltu};
          3'b100:  rsp.result = a ^ b;
          3'b101:  rsp.result = w[30] ? sra : a >> b[4:0];
          3'b110:  rsp.result = a | b;
          default: rsp.result = a & b;
        endcase
      end
      op_lui:   rsp.result = {w[31:12], 12'b0};
      op_auipc: rsp.result = req.pc + {w[31:12], 12'b0};
      op_jal, op_jalr: begin
        // Link address, jumps always go
        rsp.result = req.pc + 32'd4;
        rsp.taken  = 1'b1;
        if (w[6:0] == op_jal) begin
          rsp.target = req.pc + imm_j;
        end else begin
          rsp.target = (a + imm_i) & 32'hffff_fffe;
        end
      end
      op_branch: begin
        // Writeback slot carries rs1 - rs2
        rsp.result = a - b;
        case (f3)
          3'b000:  rsp.taken = (a == b);
          3'b001:  rsp.taken = (a != b);
          3'b100:  rsp.taken = lt;
          3'b101:  rsp.taken = !lt;
          3'b110:  rsp.taken = ltu;
          3'b111:  rsp.taken = !ltu;
          default: rsp.taken = 1'b0;
        endcase
        rsp.target = req.pc + imm_b;
      end
      default: rsp = '0;
    endcase
    return rsp;
  endfunction

  // Random operand, biased towards 0, all ones, min and max signed
  function automatic logic [31:0] rand_operand();
    logic [31:0] pick;
    pick = $random(seed);
    case (pick[2:0])
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'hffff_ffff;
      3'd2:    return 32'h8000_0000;
      3'd3:    return 32'h7fff_ffff;
      3'd4:    return 32'h0000_0001;
      default: return $random(seed);
    endcase
  endfunction

  // Kind 0 ALU, 1 upper and jumps, 2 branches, 3 unknown opcodes
  function automatic ex_req_t gen_req(input logic [1:0] kind);
    ex_req_t     req;
    logic [31:0] r;
    logic [31:0] imm;
    logic [31:0] word;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic        alt;
    r            = $random(seed);
    imm          = rand_operand();
    f3           = r[14:12];
    word         = r;
    req.pc       = $random(seed) & 32'hffff_fffc;
    req.rs1_data = rand_operand();
    req.rs2_data = rand_operand();
    case (kind)
      2'd0: begin
        // funct7 bit 5 only where it selects sub or sra
        alt  = r[1] && (f3 == 3'b000 || f3 == 3'b101);
        word = {1'b0, alt, 5'b0, r[24:20], r[19:15], f3, r[11:7], r[0] ? op_op : op_imm};
        if (!r[0]) begin
          if (f3 == 3'b001 || f3 == 3'b101) begin
            // shamt of 0 or 31 comes from the corner values
            word[24:20] = imm[4:0];
          end else begin
            word[31:20] = imm[11:0];
          end
        end
      end
      2'd1: begin
        case (r[1:0])
          2'd0:    opc = op_lui;
          2'd1:    opc = op_auipc;
          2'd2:    opc = op_jal;
          default: opc = op_jalr;
        endcase
        word = {r[31:7], opc};
      end
      2'd2: begin
        // 010 and 011 fold onto beq and bne
        if (f3[2:1] == 2'b01) begin
          f3[1] = 1'b0;
        end
        word = {r[31:15], f3, r[11:7], op_branch};
        if (r[6:5] == 2'd0) begin
          req.rs2_data = req.rs1_data;
        end else if (r[6:5] == 2'd1) begin
          req.rs1_data = $random(seed);
          req.rs2_data = $random(seed);
        end
      end
      default: begin
        // Loads, stores, fence, system, AMO, FP and two unused codes
        case (r[2:0])
          3'd0:    opc = 7'b0000011;
          3'd1:    opc = 7'b0100011;
          3'd2:    opc = 7'b0001111;
          3'd3:    opc = 7'b1110011;
          3'd4:    opc = 7'b0000000;
          3'd5:    opc = 7'b1111111;
          3'd6:    opc = 7'b0101111;
          default: opc = 7'b1010011;
        endcase
        word = {r[31:7], opc};
      end
    endcase
    req.instr = word;
    return req;
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    check_count++;
    assert (act === exp) else begin
      $display("Error: %s expected %h got %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_rsp(input ex_rsp_t exp);
    check_field("out_rsp.result", exp.result, out_rsp.result);
    check_field("out_rsp.taken", 32'(exp.taken), 32'(out_rsp.taken));
    check_field("out_rsp.target", exp.target, out_rsp.target);
  endtask

  // One strobe, wait for the response, then check it holds
  task automatic run_one(input ex_req_t req);
    ex_rsp_t exp;
    int      waited;
    exp      = model_rsp(req);
    in_req   = req;
    in_valid = 1'b1;
    @(negedge clk);
    in_valid = 1'b0;
    // Junk on the bus must not reach the output
    in_req   = {$random(seed), $random(seed), $random(seed), $random(seed)};
    waited   = 1;
    while (!out_valid && waited < resp_timeout) begin
      @(negedge clk);
      waited++;
    end
    check_count++;
    assert (out_valid && waited == 1) else begin
      if (!out_valid) begin
        $display("No response within %0d cycles of the strobe", resp_timeout);
      end else begin
        $display("Response came %0d cycles after the strobe instead of one", waited);
      end
      error_count++;
    end
    check_rsp(exp);
    @(negedge clk);
    check_field("out_valid", 32'd0, 32'(out_valid));
    check_rsp(exp);
  endtask

  task automatic run_test(input string name, input logic [1:0] kind, input int n);
    int errs_before;
    errs_before = error_count;
    for (int i = 0; i < n; i++) begin
      run_one(gen_req(kind));
    end
    $display("test %s: %0d requests, %0d errors", name, n, error_count - errs_before);
  endtask

  // Strobe every cycle, each response due on the next cycle
  task automatic run_burst(input int n);
    ex_rsp_t     pending[$];
    ex_req_t     req;
    logic [31:0] pick;
    int          errs_before;
    errs_before = error_count;
    for (int i = 0; i < n; i++) begin
      pick     = $random(seed);
      req      = gen_req(pick[1:0]);
      pending.push_back(model_rsp(req));
      in_req   = req;
      in_valid = 1'b1;
      @(negedge clk);
      check_field("out_valid", 32'd1, 32'(out_valid));
      check_rsp(pending.pop_front());
    end
    in_valid = 1'b0;
    @(negedge clk);
    check_field("out_valid", 32'd0, 32'(out_valid));
    $display("test burst: %0d requests, %0d errors", n, error_count - errs_before);
  endtask

  initial begin
    int errs_before;
    rst      = 1'b1;
    in_valid = 1'b0;
    in_req   = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // No strobe yet, output must stay cleared
    errs_before = error_count;
    for (int i = 0; i < 16; i++) begin
      in_req = {$random(seed), $random(seed), $random(seed), $random(seed)};
      @(negedge clk);
      check_field("out_valid", 32'd0, 32'(out_valid));
      check_rsp('0);
    end
    $display("test idle: 16 cycles, %0d errors", error_count - errs_before);
    run_test("alu", 2'd0, 240);
    run_test("upper_jump", 2'd1, 80);
    run_test("branch", 2'd2, 180);
    run_test("unknown", 2'd3, 24);
    run_burst(32);
    $display("Done: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== project.f ====
hw/ex_pkg.sv
hw/ex_decoder.sv
hw/ex_adder.sv
hw/ex_alu.sv
hw/ex_branch.sv
hw/ex_stage.sv
tests/ex_stage_tb.sv

// ==== Makefile ====
TOP := ex_stage_tb

.PHONY: all lint clean

# Build, run and pass only if the testbench reports success
all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir
